// File: source/aluExecute.sv
`timescale 1ns/1ps
module aluExecute import cpuPkg::*; #(
	parameter int ADDR_W = cpuPkg::ADDR_W
) (
	input  aluOp_e            aluOp,
	input  cond_e             cond,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  logic [DATA_W-1:0] s,
	input  logic [DATA_W-1:0] imm,
	input  logic [DATA_W-1:0] storeOff,
	input  logic              useImm,
	input  logic              isStore,
	output logic [DATA_W-1:0] aluRes,
	output logic [ADDR_W-1:0] memAddr,
	output logic              cmpRes
);

	logic [DATA_W-1:0] op2;
	logic [DATA_W:0]   sum;
	logic [DATA_W-1:0] ea;

	assign op2 = useImm ? imm : b;
	assign sum = {1'b0, a} + {1'b0, op2}; // carry and odd compares.

	always_comb begin
		case (aluOp)
			opAdd:   aluRes = a + op2;
			opSub:   aluRes = a - op2;
			opAnd:   aluRes = a & op2;
			opOr:    aluRes = a | op2;
			opXor:   aluRes = a ^ op2;
			opShl:   aluRes = a << op2[4:0];
			opShr:   aluRes = a >> op2[4:0];
			opAsr:   aluRes = $unsigned($signed(a) >>> op2[4:0]);
			opAddS:  aluRes = s + imm;
			default: aluRes = '0;
		endcase
	end

	always_comb begin
		case (cond)
			condEq:  cmpRes = (a == op2);
			condNe:  cmpRes = (a != op2);
			condLt:  cmpRes = ($signed(a) < $signed(op2));
			condGe:  cmpRes = ($signed(a) >= $signed(op2));
			condLe:  cmpRes = ($signed(a) <= $signed(op2));
			condGt:  cmpRes = ($signed(a) > $signed(op2));
			condLtu: cmpRes = (a < op2);
			condGeu: cmpRes = (a >= op2);
			condLeu: cmpRes = (a <= op2);
			condGtu: cmpRes = (a > op2);
			condAdc: cmpRes = sum[DATA_W];
			condOdd: cmpRes = sum[0];
			default: cmpRes = 1'b0;
		endcase
	end

	assign ea = a + (isStore ? storeOff : imm);
	assign memAddr = ea[ADDR_W-1:0];

endmodule

// File: source/cpuPkg.sv
package cpuPkg;

	localparam int DATA_W = 32;
	localparam int REG_W  = 5;
	localparam int PRED_W = 4;
	localparam int JT_W   = 24; // word jump target, shifted by two.
	localparam int ADDR_W = 25;

	localparam logic [DATA_W-1:0] NOP_INSN = 32'b000_00000_00000_00000_000000_1110_1010;

	typedef enum logic [4:0] {
		majRr     = 5'b00010,
		majAddi   = 5'b00100,
		majAndi   = 5'b01000,
		majOri    = 5'b01001,
		majXori   = 5'b01010,
		majLd     = 5'b10000,
		majSt     = 5'b10001,
		majAddis0 = 5'b10010,
		majAddis1 = 5'b10011,
		majJmp    = 5'b10111,
		majCmpi   = 5'b11000 // stands for the whole 11xxx group.
	} major_e;

	typedef enum logic [7:0] {
		funcAdd = 8'b00000100,
		funcSub = 8'b00000101,
		funcAnd = 8'b00001000,
		funcOr  = 8'b00001001,
		funcXor = 8'b00001010,
		funcShl = 8'b00010000,
		funcShr = 8'b00010001,
		funcAsr = 8'b00010010,
		funcRet = 8'b10000000,
		funcNop = 8'b11101010,
		funcCmp = 8'b11110000 // stands for the whole 1111xxxx group.
	} func_e;

	typedef enum logic [3:0] {
		condEq  = 4'd0,
		condNe  = 4'd1,
		condLt  = 4'd4,
		condGe  = 4'd5,
		condLe  = 4'd6,
		condGt  = 4'd7,
		condLtu = 4'd8,
		condGeu = 4'd9,
		condLeu = 4'd10,
		condGtu = 4'd11,
		condAdc = 4'd12,
		condOdd = 4'd14
	} cond_e;

	typedef enum logic [1:0] {
		stRun   = 2'd0,
		stLoad  = 2'd1,
		stStore = 2'd2
	} state_e;

	typedef enum logic [3:0] {
		opAdd, opSub, opAnd, opOr, opXor, opShl, opShr, opAsr, opAddS
	} aluOp_e;

endpackage

// File: source/cpuTop.sv
`timescale 1ns/1ps
module cpuTop import cpuPkg::*; #(
	parameter int ADDR_W = cpuPkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [DATA_W-1:0] insn,
	input  logic              rdy,
	input  logic [DATA_W-1:0] dati,
	output logic [ADDR_W-1:0] ip,
	output logic [ADDR_W-1:0] ad,
	output logic [DATA_W-1:0] dato,
	output logic              wr,
	output logic              rd
);

	logic [DATA_W-1:0] ir;
	logic [REG_W-1:0]  ra, rb, rt;
	logic [PRED_W-1:0] pSel, predDest;
	cond_e             cond;
	aluOp_e            aluOp;
	logic              useImm, isCmp, isLoad, isStore, isJump, link, isRet, isAlu;
	logic [DATA_W-1:0] imm, storeOff;
	logic [JT_W-1:0]   jumpTarget;
	logic [DATA_W-1:0] a, b, s;
	logic              pGuard;
	logic [DATA_W-1:0] aluRes;
	logic [ADDR_W-1:0] memAddr;
	logic              cmpRes;
	logic              loadDone;
	logic [DATA_W-1:0] wrData;
	logic              rfWr, predWr, predData;

	regFile uRegFile (
		.clk(clk), .rst(rst),
		.ra(ra), .rb(rb), .rt(rt),
		.pSel(pSel), .predDest(predDest),
		.wrData(wrData), .rfWr(rfWr), .predWr(predWr), .predData(predData),
		.a(a), .b(b), .s(s), .pGuard(pGuard)
	);

	insnDecode uDecode (
		.ir(ir), .pGuard(pGuard),
		.ra(ra), .rb(rb), .rt(rt),
		.pSel(pSel), .predDest(predDest), .cond(cond), .aluOp(aluOp),
		.useImm(useImm), .isCmp(isCmp), .isLoad(isLoad), .isStore(isStore),
		.isJump(isJump), .link(link), .isRet(isRet), .isAlu(isAlu),
		.imm(imm), .storeOff(storeOff), .jumpTarget(jumpTarget)
	);

	aluExecute #(.ADDR_W(ADDR_W)) uExecute (
		.aluOp(aluOp), .cond(cond),
		.a(a), .b(b), .s(s), .imm(imm), .storeOff(storeOff),
		.useImm(useImm), .isStore(isStore),
		.aluRes(aluRes), .memAddr(memAddr), .cmpRes(cmpRes)
	);

	seqControl #(.ADDR_W(ADDR_W)) uSeq (
		.clk(clk), .rst(rst), .insn(insn), .rdy(rdy),
		.isLoad(isLoad), .isStore(isStore), .isJump(isJump), .link(link),
		.isRet(isRet), .jumpTarget(jumpTarget), .memAddr(memAddr), .s(s),
		.ip(ip), .ad(ad), .dato(dato), .wr(wr), .rd(rd),
		.loadDone(loadDone), .ir(ir)
	);

	resultWrite uWrite (
		.isAlu(isAlu), .isCmp(isCmp), .loadDone(loadDone),
		.aluRes(aluRes), .dati(dati), .cmpRes(cmpRes),
		.wrData(wrData), .rfWr(rfWr), .predWr(predWr), .predData(predData)
	);

endmodule

// File: source/insnDecode.sv
`timescale 1ns/1ps
module insnDecode import cpuPkg::*; (
	input  logic [DATA_W-1:0] ir,
	input  logic              pGuard,
	output logic [REG_W-1:0]  ra,
	output logic [REG_W-1:0]  rb,
	output logic [REG_W-1:0]  rt,
	output logic [PRED_W-1:0] pSel,
	output logic [PRED_W-1:0] predDest,
	output cond_e             cond,
	output aluOp_e            aluOp,
	output logic              useImm,
	output logic              isCmp,
	output logic              isLoad,
	output logic              isStore,
	output logic              isJump,
	output logic              link,
	output logic              isRet,
	output logic              isAlu,
	output logic [DATA_W-1:0] imm,
	output logic [DATA_W-1:0] storeOff,
	output logic [JT_W-1:0]   jumpTarget
);

	major_e            major;
	func_e             func;
	logic [DATA_W-1:0] immS;
	logic [DATA_W-1:0] immHi;
	logic              alu, cmp, ld, st, jmp, ret;

	// fold the compare groups onto one code each.
	assign major = (ir[28:27] == 2'b11) ? majCmpi : major_e'(ir[28:24]);
	assign func = (ir[7:4] == 4'b1111) ? funcCmp : func_e'(ir[7:0]);

	assign ra = ir[18:14];
	assign rb = ir[13:9];
	assign rt = ir[23:19];
	assign pSel = ir[31:28];
	assign predDest = ir[22:19];

	assign immS = {{19{ir[12]}}, ir[12:0]};
	assign immHi = {ir[24], ir[17:0], 13'd0}; // addis, bit 24 is the sign.
	assign storeOff = {{18{ir[27]}}, ir[27:23], ir[8:0]};
	assign jumpTarget = {ir[21:0], 2'b00};

	always_comb begin
		aluOp = opAdd;
		useImm = 1'b0;
		imm = immS;
		cond = cond_e'(ir[3:0]);
		alu = 1'b0;
		cmp = 1'b0;
		ld = 1'b0;
		st = 1'b0;
		jmp = 1'b0;
		ret = 1'b0;
		casez (major)
			majRr: begin
				alu = 1'b1;
				casez (func)
					funcAdd: aluOp = opAdd;
					funcSub: aluOp = opSub;
					funcAnd: aluOp = opAnd;
					funcOr:  aluOp = opOr;
					funcXor: aluOp = opXor;
					funcShl: aluOp = opShl;
					funcShr: aluOp = opShr;
					funcAsr: aluOp = opAsr;
					funcRet: begin
						alu = 1'b0;
						ret = 1'b1;
					end
					funcCmp: begin
						alu = 1'b0;
						cmp = 1'b1;
					end
					default: alu = 1'b0; // nop and unused codes.
				endcase
			end
			majAddi, majAndi, majOri, majXori: begin
				alu = 1'b1;
				useImm = 1'b1;
				case (major)
					majAndi: aluOp = opAnd;
					majOri:  aluOp = opOr;
					majXori: aluOp = opXor;
					default: aluOp = opAdd;
				endcase
			end
			majAddis0, majAddis1: begin
				alu = 1'b1;
				aluOp = opAddS;
				imm = immHi;
			end
			majCmpi: begin
				cmp = 1'b1;
				useImm = 1'b1;
				cond = cond_e'(ir[26:23]);
			end
			majLd: ld = 1'b1;
			majSt: st = 1'b1;
			majJmp: jmp = 1'b1;
			default: ;
		endcase
	end

	assign isAlu = alu & pGuard;
	assign isCmp = cmp & pGuard;
	assign isLoad = ld & pGuard;
	assign isStore = st & pGuard;
	assign isJump = jmp & pGuard;
	assign link = jmp & ir[22] & pGuard;
	assign isRet = ret & pGuard;

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps
module regFile import cpuPkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [REG_W-1:0]  ra,
	input  logic [REG_W-1:0]  rb,
	input  logic [REG_W-1:0]  rt,
	input  logic [PRED_W-1:0] pSel,
	input  logic [PRED_W-1:0] predDest,
	input  logic [DATA_W-1:0] wrData,
	input  logic              rfWr,
	input  logic              predWr,
	input  logic              predData,
	output logic [DATA_W-1:0] a,
	output logic [DATA_W-1:0] b,
	output logic [DATA_W-1:0] s,
	output logic              pGuard
);

	logic [DATA_W-1:0]    regs [0:2**REG_W-1];
	logic [2**PRED_W-1:0] pred;
	logic                 wrPend;
	logic [REG_W-1:0]     wrIdx;
	logic [DATA_W-1:0]    wrVal;
	logic                 predPend;
	logic [PRED_W-1:0]    predIdx;
	logic                 predVal;

	assign a = (ra == '0) ? '0 : regs[ra];
	assign b = (rb == '0) ? '0 : regs[rb];
	assign s = (rt == '0) ? '0 : regs[rt];
	assign pGuard = pred[pSel];

	// writes land one slot late, no forwarding.
	always_ff @(posedge clk) begin
		wrIdx <= rt;
		wrVal <= wrData;
		predIdx <= predDest;
		predVal <= predData;
		if (wrPend)
			regs[wrIdx] <= wrVal;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPend <= 1'b0;
			predPend <= 1'b0;
			pred <= 16'h0001;
		end else begin
			wrPend <= rfWr;
			predPend <= predWr;
			if (predPend)
				pred[predIdx] <= predVal;
			pred[0] <= 1'b1; // p0 always true.
		end
	end

endmodule

// File: source/resultWrite.sv
`timescale 1ns/1ps
module resultWrite import cpuPkg::*; (
	input  logic              isAlu,
	input  logic              isCmp,
	input  logic              loadDone,
	input  logic [DATA_W-1:0] aluRes,
	input  logic [DATA_W-1:0] dati,
	input  logic              cmpRes,
	output logic [DATA_W-1:0] wrData,
	output logic              rfWr,
	output logic              predWr,
	output logic              predData
);

	// load data only on the rdy cycle.
	assign wrData = loadDone ? dati : aluRes;
	assign rfWr = isAlu | loadDone;

	assign predWr = isCmp;
	assign predData = cmpRes;

endmodule

// File: source/seqControl.sv
`timescale 1ns/1ps
module seqControl import cpuPkg::*; #(
	parameter int ADDR_W = cpuPkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [DATA_W-1:0] insn,
	input  logic              rdy,
	input  logic              isLoad,
	input  logic              isStore,
	input  logic              isJump,
	input  logic              link,
	input  logic              isRet,
	input  logic [JT_W-1:0]   jumpTarget,
	input  logic [ADDR_W-1:0] memAddr,
	input  logic [DATA_W-1:0] s,
	output logic [ADDR_W-1:0] ip,
	output logic [ADDR_W-1:0] ad,
	output logic [DATA_W-1:0] dato,
	output logic              wr,
	output logic              rd,
	output logic              loadDone,
	output logic [DATA_W-1:0] ir
);

	state_e            state;
	logic [ADDR_W-1:0] lr;
	logic [ADDR_W-1:0] ipNext;

	assign ipNext = ip + ADDR_W'(4);
	assign loadDone = (state == stLoad) && rdy;

	always_ff @(posedge clk) begin
		if (rst) begin
			ip <= '0;
			ir <= NOP_INSN;
			lr <= '0;
			state <= stRun;
			wr <= 1'b0;
			rd <= 1'b0;
		end else begin
			case (state)
				stRun: begin
					if (isLoad || isStore) begin // hold ip and ir for the access.
						ad <= memAddr;
						dato <= s;
						rd <= isLoad;
						wr <= isStore;
						state <= isLoad ? stLoad : stStore;
					end else if (isJump) begin
						ip <= ADDR_W'(jumpTarget);
						ir <= NOP_INSN; // bubble.
						if (link)
							lr <= ipNext;
					end else if (isRet) begin
						ip <= lr;
						ir <= NOP_INSN;
					end else begin
						ip <= ipNext;
						ir <= insn;
					end
				end
				stLoad, stStore: begin
					if (rdy) begin
						rd <= 1'b0;
						wr <= 1'b0;
						ip <= ipNext;
						ir <= insn;
						state <= stRun;
					end
				end
				default: state <= stRun;
			endcase
		end
	end

endmodule

// File: verification/cpuTb.sv
`timescale 1ns/1ps
module cpuTb import cpuPkg::*; ();

	logic              clk = 1'b0;
	logic              rst = 1'b1;
	logic              hold = 1'b1;
	logic [DATA_W-1:0] insn, dati, dato;
	logic [ADDR_W-1:0] ip, ad, lastIp;
	logic              rdy, wr, rd;
	logic [31:0]       lfsr = 32'd93240;
	logic [31:0]       prog [0:1023];
	logic [31:0]       refMem [0:4095];
	logic              expStore [$];
	logic [ADDR_W-1:0] expAddr [$];
	logic [DATA_W-1:0] expData [$];
	int                pc;

	always #4 clk = ~clk;

	cpuTop #(.ADDR_W(ADDR_W)) DUT (
		.clk(clk), .rst(rst), .insn(insn), .rdy(rdy), .dati(dati),
		.ip(ip), .ad(ad), .dato(dato), .wr(wr), .rd(rd)
	);

	tbMemory mem (
		.clk(clk), .ip(ip), .ad(ad), .dato(dato), .wr(wr), .rd(rd),
		.hold(hold), .insn(insn), .rdy(rdy), .dati(dati)
	);

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return v;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkAddr(input string name, input logic [ADDR_W-1:0] exp, got);
		if (got !== exp)
			failRun($sformatf("Error: %s expected %h got %h", name, exp, got));
	endtask

	task automatic checkData(input string name, input logic [DATA_W-1:0] exp, got);
		if (got !== exp)
			failRun($sformatf("Error: %s expected %h got %h", name, exp, got));
	endtask

	task automatic checkStrobe(input logic [1:0] exp, got);
		if (got !== exp)
			failRun($sformatf("Error: {wr,rd} expected %h got %h", exp, got));
	endtask

	function automatic logic [31:0] encImm(input logic [2:0] g, input logic [4:0] maj,
			input logic [4:0] rt, input logic [4:0] ra, input logic [13:0] low);
		return {g, maj, rt, ra, low};
	endfunction

	// either unguarded or a random predicate.
	function automatic logic [2:0] pickGuard();
		return randBits(1) ? 3'd0 : 3'(randBits(3));
	endfunction

	function automatic logic [3:0] pickCond();
		logic [47:0] codes;
		codes = 48'h0145_6789_ABCE;
		return codes[4 * (randBits(4) % 12) +: 4];
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[pc] = w;
		pc++;
	endtask

	task automatic buildProgram();
		logic [63:0] funcs;
		logic [19:0] immMaj;
		logic [3:0]  c;
		logic [3:0]  pd;
		funcs = 64'h0405_0809_0A10_1112;
		immMaj = {5'b00100, 5'b01000, 5'b01001, 5'b01010};
		for (int i = 0; i < 1024; i++)
			prog[i] = 32'd0;
		for (int i = 0; i < 4096; i++)
			refMem[i] = {i[11:0], ~i[11:0], i[11:4]};
		pc = 0;
		emit(encImm(3'd0, 5'b00010, 5'd1, 5'd0, {6'd0, 8'hF0})); // p1 = (r0 == r0).
		emit(32'd0);
		for (int i = 1; i < 32; i++)
			emit(encImm(3'd0, 5'b10000, 5'(i), 5'd0, {1'b0, 13'(randBits(13))}));
		emit(32'd0); // last load lands here.
		for (int n = 0; n < 80; n++) begin
			pd = 4'(2 + randBits(4) % 14); // p1 stays true.
			case (randBits(4))
				0, 1, 2, 3, 15: emit(encImm(pickGuard(), 5'b00010, 5'(randBits(5)),
					5'(randBits(5)), {5'(randBits(5)), 1'b0, funcs[8 * randBits(3) +: 8]}));
				4: emit(encImm(pickGuard(), immMaj[5 * randBits(2) +: 5], 5'(randBits(5)),
					5'(randBits(5)), 14'(randBits(14))));
				5: emit(encImm(pickGuard(), {4'b1001, 1'(randBits(1))}, 5'(randBits(5)),
					5'(randBits(5)), 14'(randBits(14))));
				6: emit(encImm(pickGuard(), 5'b00010, {1'b0, pd}, 5'(randBits(5)),
					{5'(randBits(5)), 1'b0, 4'hF, pickCond()}));
				7: begin
					c = pickCond();
					emit(encImm(pickGuard(), {2'b11, c[3:1]}, {c[0], pd}, 5'(randBits(5)),
						14'(randBits(14))));
				end
				12: emit(encImm(pickGuard(), 5'b10000, 5'(randBits(5)), 5'd0,
					{1'b0, 13'(randBits(13))}));
				13: begin
					emit({pickGuard(), 5'b10111, 2'b00, 22'(pc + 2)}); // skip one word.
					emit(encImm(3'd0, 5'b10001, 5'(randBits(5)), 5'd0, {5'd0, 9'(randBits(9))}));
				end
				14: begin
					emit({3'd0, 5'b10111, 2'b01, 22'd512}); // call.
					emit(encImm(3'd0, 5'b10001, 5'(randBits(5)), 5'd0, {5'd0, 9'(randBits(9))}));
				end
				default: emit(encImm(pickGuard(), 5'b10001, 5'(randBits(5)), 5'(randBits(5)),
					{5'd0, 9'(randBits(9))}));
			endcase
		end
		emit({3'd0, 5'b10111, 2'b00, 22'(pc)}); // halt loop.
		pc = 512;
		emit(encImm(3'd0, 5'b10001, 5'(randBits(5)), 5'd3, {5'd0, 9'(randBits(9))}));
		emit(encImm(3'd0, 5'b10001, 5'(randBits(5)), 5'd4, {5'd0, 9'(randBits(9))}));
		emit(encImm(3'd0, 5'b00010, 5'd0, 5'd0, {6'd0, 8'h80})); // return.
	endtask

	function automatic logic [31:0] aluRef(input logic [7:0] f, input logic [31:0] x, y);
		case (f)
			8'h04: return x + y;
			8'h05: return x - y;
			8'h08: return x & y;
			8'h09: return x | y;
			8'h0A: return x ^ y;
			8'h10: return x << y[4:0];
			8'h11: return x >> y[4:0];
			default: return 32'($signed(x) >>> y[4:0]);
		endcase
	endfunction

	function automatic logic condRef(input logic [3:0] c, input logic [31:0] x, y);
		logic [32:0] t;
		t = {1'b0, x} + {1'b0, y};
		case (c)
			4'd0: return x == y;
			4'd1: return x != y;
			4'd4: return $signed(x) < $signed(y);
			4'd5: return $signed(x) >= $signed(y);
			4'd6: return $signed(x) <= $signed(y);
			4'd7: return $signed(x) > $signed(y);
			4'd8: return x < y;
			4'd9: return x >= y;
			4'd10: return x <= y;
			4'd11: return x > y;
			4'd12: return t[32];
			4'd14: return t[0];
			default: return 1'b0;
		endcase
	endfunction

	// in-order run with writes visible two slots later.
	function automatic logic runModel();
		logic [31:0]       r [0:31];
		logic [15:0]       p;
		logic [ADDR_W-1:0] pcM, lr, nextPc, addr;
		logic [31:0]       w, av, bv, sv, op2, imm, res;
		logic [3:0]        cond;
		logic              wrR, wrP, halt, pendR, pendP, pendPv;
		logic [4:0]        pendIdx;
		logic [3:0]        pendPi;
		logic [31:0]       pendVal;
		p = 16'h0001;
		pcM = '0;
		lr = '0;
		halt = 1'b0;
		pendR = 1'b0;
		pendP = 1'b0;
		for (int steps = 0; steps < 10000 && !halt; steps++) begin
			w = prog[pcM[11:2]];
			av = (w[18:14] == 5'd0) ? 32'd0 : r[w[18:14]];
			bv = (w[13:9] == 5'd0) ? 32'd0 : r[w[13:9]];
			sv = (w[23:19] == 5'd0) ? 32'd0 : r[w[23:19]];
			imm = {{19{w[12]}}, w[12:0]};
			nextPc = pcM + ADDR_W'(4);
			cond = w[3:0];
			op2 = bv;
			res = '0;
			wrR = 1'b0;
			wrP = 1'b0;
			if (p[w[31:28]]) begin
				if (w[28:27] == 2'b11) begin
					cond = w[26:23];
					op2 = imm;
					wrP = 1'b1;
				end else case (w[28:24])
					5'b00010: case (w[7:0])
						8'h04, 8'h05, 8'h08, 8'h09, 8'h0A, 8'h10, 8'h11, 8'h12: begin
							res = aluRef(w[7:0], av, bv);
							wrR = 1'b1;
						end
						8'h80: nextPc = lr;
						default: wrP = (w[7:4] == 4'hF);
					endcase
					5'b00100, 5'b01000, 5'b01001, 5'b01010: begin
						res = aluRef((w[28:24] == 5'b00100) ? 8'h04 : {4'h0, w[27:24]}, av, imm);
						wrR = 1'b1;
					end
					5'b10010, 5'b10011: begin
						res = sv + {w[24], w[17:0], 13'd0};
						wrR = 1'b1;
					end
					5'b10000: begin
						addr = ADDR_W'(av + imm);
						res = refMem[addr[13:2]];
						wrR = 1'b1;
						expStore.push_back(1'b0);
						expAddr.push_back(addr);
						expData.push_back(res);
					end
					5'b10001: begin
						addr = ADDR_W'(av + {{18{w[27]}}, w[27:23], w[8:0]});
						refMem[addr[13:2]] = sv;
						expStore.push_back(1'b1);
						expAddr.push_back(addr);
						expData.push_back(sv);
					end
					5'b10111: begin
						nextPc = ADDR_W'({w[21:0], 2'b00});
						if (w[22])
							lr = pcM + ADDR_W'(8); // ip already points past the call.
						halt = (nextPc == pcM);
					end
					default: ;
				endcase
			end
			if (pendR)
				r[pendIdx] = pendVal;
			if (pendP)
				p[pendPi] = pendPv;
			p[0] = 1'b1;
			pendR = wrR;
			pendIdx = w[23:19];
			pendVal = res;
			pendP = wrP;
			pendPi = w[22:19];
			pendPv = condRef(cond, av, op2);
			pcM = nextPc;
		end
		return halt;
	endfunction

	always @(posedge clk) begin
		hold <= (randBits(2) != 32'd0); // mostly stalls.
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (wr || rd)
				checkAddr("ip", lastIp, ip);
			if ((wr || rd) && rdy) begin
				if (expStore.size() == 0) begin
					failRun("a bus transfer came after the last expected one");
				end else begin
					checkStrobe({expStore[0], !expStore[0]}, {wr, rd});
					checkAddr("ad", expAddr[0], ad);
					if (wr)
						checkData("dato", expData[0], dato);
					void'(expStore.pop_front());
					void'(expAddr.pop_front());
					void'(expData.pop_front());
				end
			end
		end
		lastIp <= ip;
	end

	initial begin
		int cycles;
		buildProgram();
		for (int i = 0; i < 1024; i++)
			mem.imem[i] = prog[i];
		for (int i = 0; i < 4096; i++)
			mem.dmem[i] = refMem[i];
		if (!runModel())
			failRun("the reference model never reached the final halt loop");
		repeat (10) @(posedge clk);
		checkAddr("ip", '0, ip);
		checkStrobe(2'b00, {wr, rd});
		rst <= 1'b0;
		cycles = 0;
		while (expStore.size() != 0 && cycles < 50000) begin
			@(negedge clk);
			cycles++;
		end
		if (expStore.size() != 0)
			failRun("timed out waiting for the expected bus transfers");
		cycles = 0;
		while (cycles < 200) begin // halt loop must stay quiet.
			@(negedge clk);
			cycles++;
		end
		$display("Test OK");
		$finish;
	end

endmodule

// File: verification/tbMemory.sv
`timescale 1ns/1ps
module tbMemory import cpuPkg::*; (
	input  logic              clk,
	input  logic [ADDR_W-1:0] ip,
	input  logic [ADDR_W-1:0] ad,
	input  logic [DATA_W-1:0] dato,
	input  logic              wr,
	input  logic              rd,
	input  logic              hold,
	output logic [DATA_W-1:0] insn,
	output logic              rdy,
	output logic [DATA_W-1:0] dati
);

	logic [DATA_W-1:0] imem [0:1023]; // filled by the testbench.
	logic [DATA_W-1:0] dmem [0:4095];

	assign insn = imem[ip[11:2]]; // combinational fetch.
	assign rdy = (wr | rd) & ~hold;
	assign dati = dmem[ad[13:2]];

	always @(posedge clk) begin
		if (wr && rdy)
			dmem[ad[13:2]] <= dato;
	end

endmodule

// File: vlog.f
source/cpuPkg.sv
source/regFile.sv
source/insnDecode.sv
source/aluExecute.sv
source/seqControl.sv
source/resultWrite.sv
source/cpuTop.sv
verification/tbMemory.sv
verification/cpuTb.sv
